/* conv_pkg.sv */
`default_nettype none

package conv_pkg;

	// Data widths
	localparam int PIX_W  = 8;                // Pixel and weight width
	localparam int KERNEL = 3;                // Kernel side length
	localparam int SUM_W  = 20;               // Holds nine 255*255 products

	// Control word from the host
	typedef enum logic [1:0] {
		OP_END   = 2'd0,                      // Final, no more work
		OP_START = 2'd1,                      // Begin computing
		OP_HOLD  = 2'd2                       // Back to waiting, drop buffered rows
	} ctrl_op_t;

	// Controller states
	typedef enum logic [1:0] {
		ST_FINISH  = 2'd1,                    // Sticky end state
		ST_WAIT    = 2'd2,                    // Idle, rows ignored
		ST_COMPUTE = 2'd3                     // Rows accepted, windows formed
	} conv_state_t;

	// One 3x3 kernel
	// Weight r*3+j sits at bits 8*(r*3+j), row 0 is the oldest row
	typedef struct packed {
		logic [KERNEL*KERNEL-1:0][PIX_W-1:0] w;   // Nine weights, index 0 in the low byte
	} kernel_t;

endpackage

`default_nettype wire

/* conv_ctrl.sv */
`default_nettype none

module conv_ctrl import conv_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  ctrl_op_t i_ctrl,          // Opcode from host
	output logic     o_compute_en,    // High while rows may be accepted
	output logic     o_clear,         // One-cycle pulse after a HOLD
	output logic     o_finish         // High in ST_FINISH
);

	conv_state_t state_q;
	conv_state_t state_d;
	logic        hold_take;           // HOLD taken this cycle

	// Next state
	always_comb begin
		state_d   = state_q;
		hold_take = 1'b0;
		case (state_q)
			ST_WAIT: begin
				if (i_ctrl == OP_START) begin
					state_d = ST_COMPUTE;
				end else if (i_ctrl == OP_END) begin
					state_d = ST_FINISH;
				end
			end
			ST_COMPUTE: begin
				if (i_ctrl == OP_HOLD) begin
					state_d   = ST_WAIT;
					hold_take = 1'b1;     // Row count gets dropped
				end else if (i_ctrl == OP_END) begin
					state_d = ST_FINISH;
				end
			end
			ST_FINISH: begin
				state_d = ST_FINISH;      // Sticky
			end
			default: begin
				state_d = ST_WAIT;        // Unused encoding recovers to idle
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q <= ST_WAIT;
			o_clear <= 1'b0;
		end else begin
			state_q <= state_d;
			o_clear <= hold_take;         // Lands while in ST_WAIT, before any new row
		end
	end

	assign o_compute_en = (state_q == ST_COMPUTE);
	assign o_finish     = (state_q == ST_FINISH);

	// Nothing leaves the end state short of a reset
	a_finish_sticky: assert property (@(posedge clk) disable iff (!rst)
		o_finish |=> o_finish)
		else $error("finish flag dropped");

endmodule

`default_nettype wire

/* row_window.sv */
`default_nettype none

module row_window import conv_pkg::*; #(
	parameter int LANES = 8                            // Pixels per row beat, 3 or more
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [LANES*PIX_W-1:0]        i_row,       // Pixel 0 in the low byte
	input  logic                          i_row_valid,
	input  logic                          i_stride,    // 0 stride 1, 1 stride 2
	input  logic                          i_compute_en,
	input  logic                          i_clear,     // Forget buffered rows
	output logic [KERNEL*LANES*PIX_W-1:0] o_rows,      // Row 0 oldest, in the low bits
	output logic                          o_win_valid  // New window on o_rows
);

	localparam int ROW_W = LANES * PIX_W;

	logic [KERNEL-1:0][ROW_W-1:0] rows_q;              // Index KERNEL-1 is the newest
	logic [1:0]                   cnt_q;               // Accepted rows, saturates at KERNEL
	logic                         phase_q;             // Low before odd-numbered rows
	logic                         accept;
	logic                         win_form;

	assign accept = i_row_valid && i_compute_en;

	// Third row onward, and with stride 2 only the odd-numbered ones
	assign win_form = accept && (cnt_q >= 2'(KERNEL - 1)) && (!i_stride || !phase_q);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rows_q      <= '0;
			cnt_q       <= '0;
			phase_q     <= 1'b0;
			o_win_valid <= 1'b0;
		end else begin
			o_win_valid <= win_form;
			if (i_clear) begin
				cnt_q   <= '0;                         // Next window needs three fresh rows
				phase_q <= 1'b0;
			end else if (accept) begin
				if (cnt_q != 2'(KERNEL)) begin
					cnt_q <= cnt_q + 2'd1;
				end
				phase_q <= ~phase_q;                   // Tracks odd/even row number
			end
			if (accept) begin
				for (int r = 0; r < KERNEL - 1; r++) begin
					rows_q[r] <= rows_q[r+1];          // Age the older rows
				end
				rows_q[KERNEL-1] <= i_row;
			end
		end
	end

	assign o_rows = rows_q;

	// A window always follows an accepted row with a full buffer
	a_three_rows: assert property (@(posedge clk) disable iff (!rst)
		o_win_valid |-> ($past(accept) && cnt_q == 2'(KERNEL)))
		else $error("window formed before three rows were accepted");

endmodule

`default_nettype wire

/* weight_store.sv */
`default_nettype none

module weight_store import conv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  kernel_t i_weight,         // Full kernel in one beat
	input  logic    i_weight_valid,   // Load strobe, honored in any state
	output kernel_t o_kernel          // Active kernel to the dot array
);

	kernel_t kernel_q;

	// Single kernel slot
	// New weights reach products of windows formed at the load edge
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			kernel_q <= '0;           // Zero kernel until first load
		end else if (i_weight_valid) begin
			kernel_q <= i_weight;
		end
	end

	assign o_kernel = kernel_q;

endmodule

`default_nettype wire

/* dot_array.sv */
`default_nettype none

module dot_array import conv_pkg::*; #(
	parameter int LANES = 8                              // Pixels per row, 3 or more
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [KERNEL*LANES*PIX_W-1:0] i_rows,        // Row 0 oldest, in the low bits
	input  logic                          i_win_valid,
	input  kernel_t                       i_kernel,
	output logic [(LANES-2)*SUM_W-1:0]    o_sums,        // Column c at bits c*SUM_W
	output logic                          o_sums_valid
);

	localparam int COLS   = LANES - 2;                   // Horizontal window positions
	localparam int TAPS   = KERNEL * KERNEL;
	localparam int PROD_W = 2 * PIX_W;

	logic [KERNEL-1:0][LANES-1:0][PIX_W-1:0] pix;        // pix[row][lane]
	logic [COLS-1:0][TAPS-1:0][PROD_W-1:0]   prod_q;     // Stage 1
	logic [COLS-1:0][SUM_W-1:0]              sum_d;
	logic [COLS-1:0][SUM_W-1:0]              sum_q;      // Stage 2
	logic                                    valid_q1;

	assign pix = i_rows;

	// Stage 1, nine full-width products per column
	always_ff @(posedge clk) begin
		if (i_win_valid) begin
			for (int c = 0; c < COLS; c++) begin
				for (int r = 0; r < KERNEL; r++) begin
					for (int j = 0; j < KERNEL; j++) begin
						prod_q[c][r*KERNEL+j] <= PROD_W'(pix[r][c+j])
							* PROD_W'(i_kernel.w[r*KERNEL+j]);
					end
				end
			end
		end
	end

	// Adder tree per column, widened before summing
	always_comb begin
		for (int c = 0; c < COLS; c++) begin
			sum_d[c] = '0;
			for (int k = 0; k < TAPS; k++) begin
				sum_d[c] = sum_d[c] + {{(SUM_W-PROD_W){1'b0}}, prod_q[c][k]};
			end
		end
	end

	// Stage 2
	always_ff @(posedge clk) begin
		if (valid_q1) begin
			sum_q <= sum_d;
		end
	end

	// Valid travels with the data, several windows may be in flight
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			valid_q1     <= 1'b0;
			o_sums_valid <= 1'b0;
		end else begin
			valid_q1     <= i_win_valid;
			o_sums_valid <= valid_q1;
		end
	end

	assign o_sums = sum_q;

	// Rows, kernel and both stages are all loaded by the time a result shows
	a_sums_known: assert property (@(posedge clk) disable iff (!rst)
		o_sums_valid |-> !$isunknown(o_sums))
		else $error("unknown bits in valid sums");

endmodule

`default_nettype wire

/* conv_top.sv */
`default_nettype none

module conv_top import conv_pkg::*; #(
	parameter int LANES = 8                            // Pixels per row beat, 3 or more
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [LANES*PIX_W-1:0]     i_row,
	input  logic                       i_row_valid,
	input  kernel_t                    i_weight,
	input  logic                       i_weight_valid,
	input  logic                       i_stride,       // 0 stride 1, 1 stride 2
	input  ctrl_op_t                   i_ctrl,
	output logic [(LANES-2)*SUM_W-1:0] o_result,       // Column c at bits c*SUM_W
	output logic                       o_result_valid, // Two cycles after the window edge
	output logic                       o_finish
);

	logic                          compute_en;
	logic                          clear;
	logic                          win_valid;
	logic [KERNEL*LANES*PIX_W-1:0] win_rows;           // Three rows of the current window
	kernel_t                       kernel;

	conv_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.i_ctrl       (i_ctrl),
		.o_compute_en (compute_en),
		.o_clear      (clear),
		.o_finish     (o_finish)
	);

	row_window #(.LANES(LANES)) u_window (
		.clk          (clk),
		.rst          (rst),
		.i_row        (i_row),
		.i_row_valid  (i_row_valid),
		.i_stride     (i_stride),
		.i_compute_en (compute_en),
		.i_clear      (clear),
		.o_rows       (win_rows),
		.o_win_valid  (win_valid)
	);

	weight_store u_weights (
		.clk            (clk),
		.rst            (rst),
		.i_weight       (i_weight),
		.i_weight_valid (i_weight_valid),
		.o_kernel       (kernel)
	);

	dot_array #(.LANES(LANES)) u_dot (
		.clk          (clk),
		.rst          (rst),
		.i_rows       (win_rows),
		.i_win_valid  (win_valid),
		.i_kernel     (kernel),
		.o_sums       (o_result),
		.o_sums_valid (o_result_valid)
	);

endmodule

`default_nettype wire

/* tb_conv_top.sv */
`default_nettype none

module tb_conv_top import conv_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          LANES     = 8;
	localparam int          ROW_W     = LANES * PIX_W;
	localparam int          COLS      = LANES - 2;
	localparam int          RES_W     = COLS * SUM_W;
	localparam logic [31:0] SEED      = 32'h7caa25f0;
	localparam int          N_RESULTS = 8 + 4 + 10;   // Windows formed by the whole stimulus

	logic                          clk;
	logic                          rst;
	logic [ROW_W-1:0]              i_row;
	logic                          i_row_valid;
	kernel_t                       i_weight;
	logic                          i_weight_valid;
	logic                          i_stride;
	ctrl_op_t                      i_ctrl;
	logic [RES_W-1:0]              o_result;
	logic                          o_result_valid;
	logic                          o_finish;

	// Reference model state
	logic [KERNEL-1:0][ROW_W-1:0]  m_rows;      // Index 2 newest
	kernel_t                       m_kernel;
	int                            m_count;     // Rows accepted since reset or HOLD
	logic                          m_compute;
	logic                          m_finish;
	logic [2:0]                    exp_v;       // Expected valid per pipeline stage
	logic [2:0][RES_W-1:0]         exp_s;
	int                            n_expected;
	int                            n_seen;

	conv_top #(.LANES(LANES)) u_conv_top (
		.clk            (clk),
		.rst            (rst),
		.i_row          (i_row),
		.i_row_valid    (i_row_valid),
		.i_weight       (i_weight),
		.i_weight_valid (i_weight_valid),
		.i_stride       (i_stride),
		.i_ctrl         (i_ctrl),
		.o_result       (o_result),
		.o_result_valid (o_result_valid),
		.o_finish       (o_finish)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;                     // 40 ns period
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	// Nine products per column with row 0 oldest and column j from the low lane
	function automatic logic [RES_W-1:0] window_sums(input logic [KERNEL-1:0][ROW_W-1:0] win,
			input kernel_t k);
		logic [RES_W-1:0] res;
		int               acc;
		res = '0;
		for (int c = 0; c < COLS; c++) begin
			acc = 0;
			for (int r = 0; r < KERNEL; r++) begin
				for (int j = 0; j < KERNEL; j++) begin
					acc += int'(win[r][(c+j)*PIX_W +: PIX_W]) * int'(k.w[r*KERNEL+j]);
				end
			end
			res[c*SUM_W +: SUM_W] = SUM_W'(acc);
		end
		return res;
	endfunction

	always @(posedge clk or negedge rst) begin : ref_model
		kernel_t                      k_now;
		logic [KERNEL-1:0][ROW_W-1:0] win;
		logic                         accept;
		logic                         form;
		if (!rst) begin
			m_rows     <= '0;
			m_kernel   <= '0;
			m_count    <= 0;
			m_compute  <= 1'b0;
			m_finish   <= 1'b0;
			exp_v      <= '0;
			exp_s      <= '0;
			n_expected <= 0;
		end else begin
			k_now  = i_weight_valid ? i_weight : m_kernel;    // Load edge already counts
			accept = i_row_valid && m_compute;
			form   = accept && (m_count >= 2) && (!i_stride || (m_count % 2 == 0));
			win    = {i_row, m_rows[2], m_rows[1]};
			m_kernel <= k_now;
			if (accept) begin
				m_rows <= win;
			end
			exp_v      <= {exp_v[1:0], form};
			exp_s      <= {exp_s[1:0], window_sums(win, k_now)};
			n_expected <= n_expected + (form ? 1 : 0);
			if (accept) begin
				m_count <= m_count + 1;
			end
			if (m_finish) begin
				m_compute <= 1'b0;                            // Sticky end
			end else if (i_ctrl == OP_END) begin
				m_finish  <= 1'b1;
				m_compute <= 1'b0;
			end else if (!m_compute && i_ctrl == OP_START) begin
				m_compute <= 1'b1;
			end else if (m_compute && i_ctrl == OP_HOLD) begin
				m_compute <= 1'b0;
				m_count   <= 0;                               // Buffered rows forgotten
			end
		end
	end

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			n_seen <= 0;
		end else if (o_result_valid) begin
			n_seen <= n_seen + 1;
		end
	end

	a_valid_match: assert property (@(posedge clk) disable iff (!rst)
		o_result_valid == exp_v[2])
		else fail_run($sformatf("** Error at %0d ns: result valid %b, model expects %b",
			$time, $sampled(o_result_valid), $sampled(exp_v[2])));

	a_sums_match: assert property (@(posedge clk) disable iff (!rst)
		o_result_valid |-> (o_result == exp_s[2]))
		else fail_run($sformatf("** Error at %0d ns: result %h, model expects %h",
			$time, $sampled(o_result), $sampled(exp_s[2])));

	a_finish_match: assert property (@(posedge clk) disable iff (!rst)
		o_finish == m_finish)
		else fail_run($sformatf("** Error at %0d ns: finish flag %b, model expects %b",
			$time, $sampled(o_finish), $sampled(m_finish)));

	task automatic next_cycle();
		@(posedge clk);
		#2;                                           // Inputs move after the edge
	endtask

	task automatic fill_kernel(input bit saturate);
		for (int k = 0; k < KERNEL * KERNEL; k++) begin
			i_weight.w[k] = saturate ? 8'hff : PIX_W'($urandom);
		end
	endtask

	task automatic load_kernel(input bit saturate);
		fill_kernel(saturate);
		i_weight_valid = 1'b1;
		next_cycle();
		i_weight_valid = 1'b0;
	endtask

	// Op stays applied afterwards as START in compute and HOLD in wait do nothing
	task automatic apply_ctrl(input ctrl_op_t op);
		i_ctrl = op;
		next_cycle();
	endtask

	// Back to back rows with an optional kernel swap on beat reload_at
	task automatic stream_rows(input int n, input int reload_at, input bit saturate);
		for (int i = 0; i < n; i++) begin
			for (int l = 0; l < LANES; l++) begin
				i_row[l*PIX_W +: PIX_W] = saturate ? 8'hff : PIX_W'($urandom);
			end
			i_row_valid = 1'b1;
			if (i == reload_at) begin
				fill_kernel(saturate);
				i_weight_valid = 1'b1;
			end
			next_cycle();
			i_weight_valid = 1'b0;
		end
		i_row_valid = 1'b0;
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		while (n_seen != n_expected || exp_v != '0) begin
			if (waited == 20) begin
				fail_run("Timeout: results did not drain within 20 cycles");
			end
			next_cycle();
			waited++;
		end
	endtask

	initial begin : stimulus
		void'($urandom(SEED));
		i_row          = '0;
		i_row_valid    = 1'b0;
		i_weight       = '0;
		i_weight_valid = 1'b0;
		i_stride       = 1'b0;
		i_ctrl         = OP_HOLD;                   // No effect while waiting
		rst            = 1'b0;
		repeat (4) @(posedge clk);
		#2 rst = 1'b1;
		stream_rows(3, -1, 1'b0);                   // Ignored while still waiting
		next_cycle();
		load_kernel(1'b0);
		apply_ctrl(OP_START);
		stream_rows(10, -1, 1'b0);                  // Stride 1 stream
		drain_results();
		apply_ctrl(OP_HOLD);
		stream_rows(4, -1, 1'b0);                   // Dropped during wait
		i_stride = 1'b1;
		apply_ctrl(OP_START);
		stream_rows(9, -1, 1'b0);                   // Odd rows only
		drain_results();
		i_stride = 1'b0;
		apply_ctrl(OP_HOLD);
		apply_ctrl(OP_START);
		stream_rows(8, 4, 1'b0);                    // Kernel swap mid stream
		stream_rows(4, 1, 1'b1);                    // All ones for the widest sums
		drain_results();
		apply_ctrl(OP_END);
		stream_rows(5, -1, 1'b0);
		apply_ctrl(OP_START);                       // Must not leave finish
		stream_rows(3, -1, 1'b0);
		drain_results();
		if (n_expected == N_RESULTS && n_seen == N_RESULTS && o_finish) begin
			$display("All tests passed!");
			$finish;
		end else begin
			fail_run("Result count or finish flag wrong at end of run");
		end
	end

endmodule

`default_nettype wire

/* files.f */
conv_pkg.sv
conv_ctrl.sv
row_window.sv
weight_store.sv
dot_array.sv
conv_top.sv
tb_conv_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_conv_top
FILELIST = files.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
